// ==== procPkg.sv ====
package procPkg;

    ////////////////////////////////////////////////////////////
    // word and memory sizes
    ////////////////////////////////////////////////////////////

    localparam int dataWidth     = 32;
    localparam int instWidth     = 32;
    localparam int regAddrWidth  = 6;
    localparam int immWidth      = 15;
    localparam int functWidth    = 4;

    localparam int progDepth     = 64;
    localparam int progAddrWidth = $clog2(progDepth);
    localparam int dmemDepth     = 128;
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    ////////////////////////////////////////////////////////////
    // instruction field positions
    ////////////////////////////////////////////////////////////

    localparam int typeBit  = 0;    // 1 means immediate type
    localparam int rsLsb    = 1;
    localparam int rdLsb    = 7;
    localparam int functLsb = 13;   // mode is the lowest funct bit
    localparam int rtLsb    = 17;
    localparam int immLsb   = 17;   // shares bits with rt

    ////////////////////////////////////////////////////////////
    // operation and sequencer encodings
    ////////////////////////////////////////////////////////////

    // value is the raw funct field {opsel, mode}
    typedef enum logic [3:0] {
        ADD   = 4'b0000,    // arithmetic group, mode 0
        SUB   = 4'b0010,
        MOV   = 4'b0100,
        INC   = 4'b0110,
        DEC   = 4'b1000,
        LOAD  = 4'b1010,
        STORE = 4'b1100,
        AND   = 4'b0001,    // logic group, mode 1
        OR    = 4'b0011,
        XOR   = 4'b0101,
        NOT   = 4'b0111,
        SLL   = 4'b1001,
        NOP   = 4'b1111     // 1110, 1011, 1101 also land here
    } aluOp_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        READ  = 2'd2,
        EXEC  = 2'd3
    } stepState_t;

endpackage

// ==== aluCore.sv ====
`timescale 1ns/10ps

module aluCore (
    input  logic [procPkg::dataWidth-1:0] opA,
    input  logic [procPkg::dataWidth-1:0] opB,
    input  procPkg::aluOp_t               opcode,
    output logic [procPkg::dataWidth-1:0] result
);
    import procPkg::*;

    ////////////////////////////////////////////////////////////
    // arithmetic group
    ////////////////////////////////////////////////////////////

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;

    assign sum  = opA + opB;    // also the load/store address
    assign diff = opA - opB;

    ////////////////////////////////////////////////////////////
    // result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            ADD: begin
                result = sum;
            end
            SUB: begin
                result = diff;
            end
            MOV: begin
                result = opA;
            end
            INC: begin
                result = opA + 1'b1;
            end
            DEC: begin
                result = opA - 1'b1;
            end
            LOAD, STORE: begin
                result = sum;       // effective address
            end
            AND: begin
                result = opA & opB;
            end
            OR: begin
                result = opA | opB;
            end
            XOR: begin
                result = opA ^ opB;
            end
            NOT: begin
                result = ~opA;
            end
            SLL: begin
                // shift by one, zero fill
                result = {opA[dataWidth-2:0], 1'b0};
            end
            default: begin
                result = '0;        // nop
            end
        endcase
    end

endmodule

// ==== fetchDecode.sv ====
`timescale 1ns/10ps

module fetchDecode #(
    parameter int regAddrWidth = procPkg::regAddrWidth,
    parameter int progDepth    = procPkg::progDepth
) (
    input  logic                          clk,
    input  logic                          clkreset,
    input  logic                          run,
    input  logic                          progWe,
    input  logic [$clog2(progDepth)-1:0]  progAddr,
    input  logic [procPkg::instWidth-1:0] progData,
    output logic [regAddrWidth-1:0]       readAddrA,
    output logic [regAddrWidth-1:0]       readAddrB,
    output logic                          execStrobe,
    output procPkg::aluOp_t               opcode,
    output logic                          isImm,
    output logic [regAddrWidth-1:0]       destAddr,
    output logic [procPkg::immWidth-1:0]  imm
);
    import procPkg::*;

    localparam int pcWidth = $clog2(progDepth);

    logic [instWidth-1:0]    progMem [progDepth];
    logic [instWidth-1:0]    instReg;
    logic [pcWidth-1:0]      pc;
    stepState_t              state;
    stepState_t              nextState;
    logic [functWidth-1:0]   funct;
    logic [regAddrWidth-1:0] rtAddr;

    // loading port, only open while stopped
    always_ff @(posedge clk) begin
        if (progWe && !run) begin
            progMem[progAddr] <= progData;
        end
    end

    ////////////////////////////////////////////////////////////
    // step sequencer
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            IDLE:    nextState = run ? FETCH : IDLE;
            FETCH:   nextState = run ? READ : IDLE;
            READ:    nextState = run ? EXEC : IDLE;
            default: nextState = run ? FETCH : IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            state      <= IDLE;
            pc         <= '0;
            execStrobe <= 1'b0;
        end else begin
            state      <= nextState;
            execStrobe <= (nextState == EXEC);   // one cycle per instruction
            if (state == EXEC) begin
                // a started EXEC always finishes, so the pc moves on
                pc <= (pc == pcWidth'(progDepth - 1)) ? '0 : pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            instReg <= progMem[pc];
        end
    end

    ////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////

    assign funct    = instReg[functLsb +: functWidth];
    assign isImm    = instReg[typeBit];
    assign destAddr = instReg[rdLsb +: regAddrWidth];
    assign rtAddr   = instReg[rtLsb +: regAddrWidth];
    assign imm      = instReg[immLsb +: immWidth];

    always_comb begin
        case (funct)
            ADD, SUB, MOV, INC, DEC, LOAD, STORE,
            AND, OR, XOR, NOT, SLL: opcode = aluOp_t'(funct);
            default:                opcode = NOP;
        endcase
    end

    assign readAddrA = instReg[rsLsb +: regAddrWidth];
    assign readAddrB = (opcode == STORE) ? destAddr : rtAddr;   // store data sits in rd

    // the strobe only follows a completed READ step
    assert property (@(posedge clk) disable iff (!clkreset)
        execStrobe |-> (state == EXEC) && ($past(state) == READ));

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps

module regFile #(
    parameter int regAddrWidth = procPkg::regAddrWidth
) (
    input  logic                          clk,
    input  logic                          clkreset,
    input  logic [regAddrWidth-1:0]       readAddrA,
    input  logic [regAddrWidth-1:0]       readAddrB,
    input  logic                          regWe,
    input  logic [regAddrWidth-1:0]       regWriteAddr,
    input  logic [procPkg::dataWidth-1:0] regWriteData,
    output logic [procPkg::dataWidth-1:0] readDataA,
    output logic [procPkg::dataWidth-1:0] readDataB
);
    import procPkg::*;

    localparam int regCount = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [regCount];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe) begin
            regs[regWriteAddr] <= regWriteData;
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // sampled every cycle, the EXEC step uses what READ captured
    always_ff @(posedge clk) begin
        if (readAddrA == '0) begin
            readDataA <= '0;    // r0 is hardwired
        end else begin
            readDataA <= regs[readAddrA];
        end

        if (readAddrB == '0) begin
            readDataB <= '0;
        end else begin
            readDataB <= regs[readAddrB];
        end
    end

    // the execute stage drops writebacks to r0 before they get here
    assert property (@(posedge clk) disable iff (!clkreset)
        regWe |-> (regWriteAddr != '0));

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/10ps

module executeUnit #(
    parameter int regAddrWidth = procPkg::regAddrWidth,
    parameter int dmemDepth    = procPkg::dmemDepth
) (
    input  logic                          clk,
    input  logic                          clkreset,
    input  logic                          execStrobe,
    input  procPkg::aluOp_t               opcode,
    input  logic                          isImm,
    input  logic [regAddrWidth-1:0]       destAddr,
    input  logic [procPkg::immWidth-1:0]  imm,
    input  logic [procPkg::dataWidth-1:0] readDataA,
    input  logic [procPkg::dataWidth-1:0] readDataB,
    output logic                          regWe,
    output logic [regAddrWidth-1:0]       regWriteAddr,
    output logic [procPkg::dataWidth-1:0] regWriteData,
    output logic                          storeValid,
    output logic [$clog2(dmemDepth)-1:0]  storeAddr,
    output logic [procPkg::dataWidth-1:0] storeData
);
    import procPkg::*;

    localparam int memAddrWidth = $clog2(dmemDepth);

    logic [dataWidth-1:0]    dmem [dmemDepth];
    logic [dataWidth-1:0]    opB;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    loadData;
    logic [memAddrWidth-1:0] memAddr;
    logic                    isStore;
    logic                    writesReg;

    ////////////////////////////////////////////////////////////
    // operand select and alu
    ////////////////////////////////////////////////////////////

    assign opB = isImm ? {{(dataWidth - immWidth){imm[immWidth-1]}}, imm} : readDataB;

    aluCore uAlu (
        .opA    (readDataA),
        .opB    (opB),
        .opcode (opcode),
        .result (aluResult)
    );

    assign memAddr   = aluResult[memAddrWidth-1:0];    // upper address bits ignored
    assign loadData  = dmem[memAddr];
    assign isStore   = (opcode == STORE);
    assign writesReg = (opcode != STORE) && (opcode != NOP) && (destAddr != '0);

    ////////////////////////////////////////////////////////////
    // data memory and strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            regWe      <= 1'b0;
            storeValid <= 1'b0;
            for (int i = 0; i < dmemDepth; i++) begin
                dmem[i] <= '0;
            end
        end else begin
            regWe      <= execStrobe && writesReg;
            storeValid <= execStrobe && isStore;
            if (execStrobe && isStore) begin
                dmem[memAddr] <= readDataB;     // rd value on port B
            end
        end
    end

    // result side, held between strobes
    always_ff @(posedge clk) begin
        if (execStrobe) begin
            regWriteAddr <= destAddr;
            regWriteData <= (opcode == LOAD) ? loadData : aluResult;
            storeAddr    <= memAddr;
            storeData    <= readDataB;
        end
    end

    // one event per instruction, and never both kinds
    assert property (@(posedge clk) disable iff (!clkreset)
        !(regWe && storeValid));

    assert property (@(posedge clk) disable iff (!clkreset)
        (regWe || storeValid) |=> !(regWe || storeValid));

endmodule

// ==== procCore.sv ====
`timescale 1ns/10ps

module procCore #(
    parameter int regAddrWidth = procPkg::regAddrWidth,
    parameter int progDepth    = procPkg::progDepth,
    parameter int dmemDepth    = procPkg::dmemDepth
) (
    input  logic                          clk,
    input  logic                          clkreset,
    input  logic                          run,
    input  logic                          progWe,
    input  logic [$clog2(progDepth)-1:0]  progAddr,
    input  logic [procPkg::instWidth-1:0] progData,
    output logic                          wbValid,
    output logic [regAddrWidth-1:0]       wbAddr,
    output logic [procPkg::dataWidth-1:0] wbData,
    output logic                          storeValid,
    output logic [$clog2(dmemDepth)-1:0]  storeAddr,
    output logic [procPkg::dataWidth-1:0] storeData
);
    import procPkg::*;

    logic [regAddrWidth-1:0] readAddrA;
    logic [regAddrWidth-1:0] readAddrB;
    logic [dataWidth-1:0]    readDataA;
    logic [dataWidth-1:0]    readDataB;
    logic                    execStrobe;
    aluOp_t                  opcode;
    logic                    isImm;
    logic [regAddrWidth-1:0] destAddr;
    logic [immWidth-1:0]     imm;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    fetchDecode #(
        .regAddrWidth (regAddrWidth),
        .progDepth    (progDepth)
    ) uFetch (
        .clk        (clk),
        .clkreset   (clkreset),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .readAddrA  (readAddrA),
        .readAddrB  (readAddrB),
        .execStrobe (execStrobe),
        .opcode     (opcode),
        .isImm      (isImm),
        .destAddr   (destAddr),
        .imm        (imm)
    );

    // writeback port doubles as the external wb strobe
    regFile #(
        .regAddrWidth (regAddrWidth)
    ) uRegs (
        .clk          (clk),
        .clkreset     (clkreset),
        .readAddrA    (readAddrA),
        .readAddrB    (readAddrB),
        .regWe        (wbValid),
        .regWriteAddr (wbAddr),
        .regWriteData (wbData),
        .readDataA    (readDataA),
        .readDataB    (readDataB)
    );

    executeUnit #(
        .regAddrWidth (regAddrWidth),
        .dmemDepth    (dmemDepth)
    ) uExec (
        .clk          (clk),
        .clkreset     (clkreset),
        .execStrobe   (execStrobe),
        .opcode       (opcode),
        .isImm        (isImm),
        .destAddr     (destAddr),
        .imm          (imm),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .regWe        (wbValid),
        .regWriteAddr (wbAddr),
        .regWriteData (wbData),
        .storeValid   (storeValid),
        .storeAddr    (storeAddr),
        .storeData    (storeData)
    );

endmodule

// ==== procChecker.sv ====
`timescale 1ns/10ps

module procChecker #(
    parameter int regAddrWidth = procPkg::regAddrWidth,
    parameter int progDepth    = procPkg::progDepth,
    parameter int dmemDepth    = procPkg::dmemDepth
) (
    input  logic                          clk,
    input  logic                          clkreset,
    input  logic                          run,
    input  logic                          progWe,
    input  logic [$clog2(progDepth)-1:0]  progAddr,
    input  logic [procPkg::instWidth-1:0] progData,
    input  logic                          wbValid,
    input  logic [regAddrWidth-1:0]       wbAddr,
    input  logic [procPkg::dataWidth-1:0] wbData,
    input  logic                          storeValid,
    input  logic [$clog2(dmemDepth)-1:0]  storeAddr,
    input  logic [procPkg::dataWidth-1:0] storeData,
    output logic                          allSeen,
    output int                            valueErrors,
    output int                            eventErrors,
    output int                            pendingEvents
);
    import procPkg::*;

    logic [instWidth-1:0] progCopy  [progDepth];
    logic [dataWidth-1:0] modelRegs [2 ** regAddrWidth];
    logic [dataWidth-1:0] modelMem  [dmemDepth];
    bit                   expIsStore [$];
    int                   expAddr    [$];
    logic [dataWidth-1:0] expData    [$];
    bit                   built;
    int                   valueCount = 0;
    int                   eventCount = 0;

    assign valueErrors = valueCount;
    assign eventErrors = eventCount;

    task automatic clearModel();
        for (int i = 0; i < 2 ** regAddrWidth; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dmemDepth; i++) begin
            modelMem[i] = '0;
        end
        expIsStore.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic queueEvent(input bit isStore, input int addr, input logic [dataWidth-1:0] data);
        expIsStore.push_back(isStore);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model, one pass over the loaded program
    ////////////////////////////////////////////////////////////

    task automatic predictProgram();
        logic [instWidth-1:0] word;
        logic [3:0]           funct;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] value;
        int                   rd;
        int                   memIdx;
        bit                   writes;
        for (int i = 0; i < progDepth; i++) begin
            word  = progCopy[i];
            funct = word[functLsb +: 4];
            rd    = word[rdLsb +: regAddrWidth];
            opA   = modelRegs[word[rsLsb +: regAddrWidth]];
            if (word[typeBit]) begin
                opB = {{(dataWidth - immWidth){word[immLsb + immWidth - 1]}},
                       word[immLsb +: immWidth]};
            end else if (funct == STORE) begin
                opB = modelRegs[rd];    // store reads rd on port B
            end else begin
                opB = modelRegs[word[rtLsb +: regAddrWidth]];
            end
            memIdx = (opA + opB) % dmemDepth;
            writes = 1'b1;
            case (funct)
                ADD:     value = opA + opB;
                SUB:     value = opA - opB;
                MOV:     value = opA;
                INC:     value = opA + 1;
                DEC:     value = opA - 1;
                AND:     value = opA & opB;
                OR:      value = opA | opB;
                XOR:     value = opA ^ opB;
                NOT:     value = ~opA;
                SLL:     value = opA << 1;
                LOAD:    value = modelMem[memIdx];
                STORE: begin
                    modelMem[memIdx] = modelRegs[rd];
                    queueEvent(1'b1, memIdx, modelRegs[rd]);
                    writes = 1'b0;
                end
                default: writes = 1'b0;     // unused codes
            endcase
            if (writes && rd != 0) begin
                modelRegs[rd] = value;      // r0 never written, stays zero
                queueEvent(1'b0, rd, value);
            end
        end
    endtask

    task automatic checkEvent(input bit isStore, input int addr, input logic [dataWidth-1:0] data);
        string                kind;
        bit                   wantStore;
        int                   wantAddr;
        logic [dataWidth-1:0] wantData;
        kind = isStore ? "store" : "writeback";
        if (expData.size() == 0) begin
            eventCount++;
            $display("unexpected %s to address %0d at time %0t, no event was pending",
                     kind, addr, $time);
        end else begin
            wantStore = expIsStore.pop_front();
            wantAddr  = expAddr.pop_front();
            wantData  = expData.pop_front();
            if (wantStore != isStore) begin
                eventCount++;
                $display("a %s came at time %0t where the next expected event is of the other kind",
                         kind, $time);
            end else if (wantAddr != addr || wantData !== data) begin
                valueCount++;
                $display("FAIL %0t: %s address %0d data %h, expected address %0d data %h",
                         $time, kind, addr, data, wantAddr, wantData);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sampling, on the falling edge where DUT outputs are settled
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (progWe && !run) begin
            progCopy[progAddr] = progData;  // same rule as the loading port
        end
        if (!clkreset) begin
            clearModel();
            built = 1'b0;
            allSeen <= 1'b0;
        end else begin
            if (run && !built) begin
                predictProgram();
                built = 1'b1;
            end
            if (wbValid) begin
                checkEvent(1'b0, wbAddr, wbData);
            end
            if (storeValid) begin
                checkEvent(1'b1, storeAddr, storeData);
            end
            allSeen <= built && (expData.size() == 0);
        end
        pendingEvents = expData.size();
    end

endmodule

// ==== tbProc.sv ====
`timescale 1ns/10ps

module tbProc;
    import procPkg::*;

    localparam int progCount     = 2;
    localparam int timeoutCycles = progCount * (8 + progDepth + 3 * progDepth) + 200;

    logic                     clk;
    logic                     clkreset;
    logic                     run;
    logic                     progWe;
    logic [progAddrWidth-1:0] progAddr;
    logic [instWidth-1:0]     progData;
    logic                     wbValid;
    logic [regAddrWidth-1:0]  wbAddr;
    logic [dataWidth-1:0]     wbData;
    logic                     storeValid;
    logic [dmemAddrWidth-1:0] storeAddr;
    logic [dataWidth-1:0]     storeData;
    logic                     allSeen;
    int                       valueErrors;
    int                       eventErrors;
    int                       pendingEvents;
    int                       seed;
    int                       cycleCount;

    procCore #(
        .regAddrWidth (regAddrWidth),
        .progDepth    (progDepth),
        .dmemDepth    (dmemDepth)
    ) dut (
        .clk        (clk),
        .clkreset   (clkreset),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    procChecker #(
        .regAddrWidth (regAddrWidth),
        .progDepth    (progDepth),
        .dmemDepth    (dmemDepth)
    ) scoreboard (
        .clk           (clk),
        .clkreset      (clkreset),
        .run           (run),
        .progWe        (progWe),
        .progAddr      (progAddr),
        .progData      (progData),
        .wbValid       (wbValid),
        .wbAddr        (wbAddr),
        .wbData        (wbData),
        .storeValid    (storeValid),
        .storeAddr     (storeAddr),
        .storeData     (storeData),
        .allSeen       (allSeen),
        .valueErrors   (valueErrors),
        .eventErrors   (eventErrors),
        .pendingEvents (pendingEvents)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // even words cover every funct code in both instruction types
    function automatic logic [instWidth-1:0] makeInstruction(input int index);
        logic [instWidth-1:0] word;
        logic [3:0]           funct;
        logic                 isImmType;
        word      = $random(seed);
        funct     = word[functLsb +: 4];
        isImmType = word[typeBit];
        if (index % 2 == 0) begin
            funct     = 4'(index / 2);
            isImmType = index[5];   // R-type in the first half
        end
        word[typeBit]                = isImmType;
        word[functLsb +: 4]          = funct;
        word[rsLsb +: regAddrWidth]  = regAddrWidth'($random(seed) & 7);   // only r0 to r7 for reuse
        word[rdLsb +: regAddrWidth]  = regAddrWidth'($random(seed) & 7);
        if (!isImmType) begin
            word[rtLsb +: regAddrWidth] = regAddrWidth'($random(seed) & 7);
        end else if ($random(seed) & 1) begin
            word[immLsb +: immWidth] = immWidth'($random(seed) % 16);   // small values of either sign
        end
        return word;
    endfunction

    task automatic resetDut();
        @(posedge clk);
        clkreset <= 1'b0;
        run      <= 1'b0;
        progWe   <= 1'b0;
        repeat (8) @(posedge clk);
        clkreset <= 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progDepth; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= progAddrWidth'(i);
            progData <= makeInstruction(i);
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic runProgram(input bit strayWrites);
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        while (!allSeen) begin
            if (strayWrites) begin
                progWe   <= $random(seed) & 1;  // must not reach program memory
                progAddr <= progAddrWidth'($random(seed));
                progData <= $random(seed);
            end
            @(posedge clk);
        end
        run    <= 1'b0;
        progWe <= 1'b0;
        repeat (10) @(posedge clk);     // room for any late strobe
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        seed     = 32'hf39d;
        clkreset = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int p = 0; p < progCount; p++) begin
            resetDut();
            loadProgram();
            runProgram(p == 1);
        end
        $display("errors: %0d value, %0d event", valueErrors, eventErrors);
        if (valueErrors == 0 && eventErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, %0d expected events never arrived",
                 cycleCount, pendingEvents);
        $display("errors: %0d value, %0d event", valueErrors, eventErrors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
procPkg.sv
aluCore.sv
fetchDecode.sv
regFile.sv
executeUnit.sv
procCore.sv
procChecker.sv
tbProc.sv
